//--- Bender.yml
package:
  name: overworld_renderer

sources:
  - include_dirs:
      - hw
    files:
      - hw/gamePkg.sv
      - hw/videoPkg.sv
      - hw/gameModeFsm.sv
      - hw/walkAnimator.sv
      - hw/cameraMover.sv
      - hw/scanAddrGen.sv
      - hw/pixelCompositor.sv
      - hw/overworldRenderer.sv
  - target: test
    include_dirs:
      - hw
      - verification
    files:
      - verification/tbOverworld.sv

//--- filelist.f
+incdir+hw
+incdir+verification
hw/gamePkg.sv
hw/videoPkg.sv
hw/gameModeFsm.sv
hw/walkAnimator.sv
hw/cameraMover.sv
hw/scanAddrGen.sv
hw/pixelCompositor.sv
hw/overworldRenderer.sv
verification/tbOverworld.sv

//--- hw/cameraMover.sv
`timescale 1ns/1ns
`default_nettype none

`include "overworld_defs.svh"

module cameraMover import gamePkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic stepReq,
	input animState anim,
	input logic spawn,
	input camPos spawnPos,
	input logic [3:0] collisionBits,
	output camPos camera,
	output logic [18:0] collisionAddr
);

	camPos charPos;
	logic stepOk;

	assign charPos = charOf(camera);

	// Cell under the character's top left corner
	assign collisionAddr = 19'((charPos.y >>> `MAP_SHIFT) * `MAP_W +
		(charPos.x >>> `MAP_SHIFT));

	always_comb begin
		case (anim.dir)
			up: stepOk = camera.y > `CAM_MIN_Y && !collisionBits[3];
			right: stepOk = camera.x < `CAM_MAX_X && !collisionBits[0];
			down: stepOk = camera.y < `CAM_MAX_Y && !collisionBits[1];
			default: stepOk = camera.x > `CAM_MIN_X && !collisionBits[2];
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			camera <= '0;
		end else if (spawn) begin
			camera <= spawnPos;
		end else if (frameTick && stepReq && stepOk) begin
			case (anim.dir)
				up: camera.y <= camera.y - 13'sd1;
				right: camera.x <= camera.x + 13'sd1;
				down: camera.y <= camera.y + 13'sd1;
				default: camera.x <= camera.x - 13'sd1;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/gameModeFsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "overworld_defs.svh"

module gameModeFsm import gamePkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input camPos camera,
	output gameMode mode,
	output logic spawn,
	output camPos spawnPos
);

	camPos charPos;
	logic atDoor;
	logic atExit;

	assign charPos = charOf(camera);
	assign atDoor = charPos.x > `GYM_DOOR_X0 && charPos.x < `GYM_DOOR_X1 &&
		charPos.y == `GYM_DOOR_Y;
	assign atExit = charPos.y == `GYM_EXIT_Y;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			mode <= START;
			spawn <= 1'b0;
		end else begin
			spawn <= 1'b0;
			if (frameTick) begin
				case (mode)
					START: begin
						if (keycode == `START_KEY) begin
							mode <= OVERWORLD;
							spawn <= 1'b1;
						end
					end
					OVERWORLD: begin
						if (atDoor) begin
							mode <= GYM;
							spawn <= 1'b1;
						end
					end
					GYM: begin
						if (atExit) begin
							mode <= OVERWORLD;
							spawn <= 1'b1;
						end
					end
					default: mode <= START;
				endcase
			end
		end
	end

	// Target of the next transition, valid alongside the spawn pulse
	always_ff @(posedge Clk) begin
		if (frameTick) begin
			if (mode == OVERWORLD) begin
				spawnPos <= '0;
			end else begin
				spawnPos.x <= 13'(`SPAWN_X);
				spawnPos.y <= 13'(`SPAWN_Y);
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/gamePkg.sv
`default_nettype none

`include "overworld_defs.svh"

package gamePkg;

	typedef enum logic [1:0] {
		START,
		OVERWORLD,
		GYM
	} gameMode;

	typedef enum logic [1:0] {
		up,
		right,
		down,
		left
	} walkDir;

	typedef enum logic [1:0] {
		rest1,
		stride1,
		rest2,
		stride2
	} walkPhase;

	typedef struct packed {
		walkDir dir;
		walkPhase phase;
	} animState;

	typedef struct packed {
		logic signed [12:0] x;
		logic signed [12:0] y;
	} camPos;

	// Character sits at a fixed offset from the camera corner
	function automatic camPos charOf(camPos cam);
		camPos pos;
		pos.x = 13'(cam.x + `SPRITE_X0);
		pos.y = 13'(cam.y + `SPRITE_Y0);
		return pos;
	endfunction

endpackage

`default_nettype wire

//--- hw/overworldRenderer.sv
`timescale 1ns/1ns
`default_nettype none

module overworldRenderer import gamePkg::*, videoPkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic moving,
	input walkDir direction,
	input scanIn scan,
	output romAddr rom,
	input romData data,
	output pixelOut pixel
);

	gameMode mode;
	camPos camera;
	camPos spawnPos;
	animState anim;
	logic spawn;
	logic stepReq;
	logic charHere;
	logic inMap;
	logic inMenu;

	gameModeFsm uModeFsm (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.keycode(keycode),
		.camera(camera),
		.mode(mode),
		.spawn(spawn),
		.spawnPos(spawnPos)
	);

	walkAnimator uWalk (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.moving(moving),
		.direction(direction),
		.mode(mode),
		.spawn(spawn),
		.anim(anim),
		.stepReq(stepReq)
	);

	cameraMover uCamera (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.stepReq(stepReq),
		.anim(anim),
		.spawn(spawn),
		.spawnPos(spawnPos),
		.collisionBits(data.collisionBits),
		.camera(camera),
		.collisionAddr(rom.collisionAddr)
	);

	scanAddrGen uScanAddr (
		.scan(scan),
		.camera(camera),
		.anim(anim),
		.spriteAddr(rom.spriteAddr),
		.mapAddr(rom.mapAddr),
		.menuAddr(rom.menuAddr),
		.charHere(charHere),
		.inMap(inMap),
		.inMenu(inMenu)
	);

	pixelCompositor uCompositor (
		.Clk(Clk),
		.rstN(rstN),
		.mode(mode),
		.active(scan.active),
		.charHere(charHere),
		.inMap(inMap),
		.inMenu(inMenu),
		.data(data),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

//--- hw/overworld_defs.svh
`ifndef OVERWORLD_DEFS_SVH
`define OVERWORLD_DEFS_SVH

// Visible scan area
`define SCREEN_W 640
`define SCREEN_H 480

// Sprite box on screen, fixed while the camera scrolls
`define SPRITE_X0 311
`define SPRITE_Y0 340
`define SPRITE_W 19
`define SPRITE_H 29

// Sprite sheet layout
`define SHEET_W 228
`define DIR_STRIDE 57

// One map cell covers 4 by 4 screen pixels
`define MAP_SHIFT 2
`define MAP_W 320
`define MAP_H 240

// Start menu image
`define MENU_Y0 80
`define MENU_Y1 370
`define MENU_ROW 200

// Camera travel limits
`define CAM_MIN_X (-311)
`define CAM_MAX_X 951
`define CAM_MIN_Y (-340)
`define CAM_MAX_Y 594

// Overworld spawn camera position
`define SPAWN_X 100
`define SPAWN_Y 100

// Door and exit, in character coordinates
`define GYM_DOOR_X0 411
`define GYM_DOOR_X1 440
`define GYM_DOOR_Y 420
`define GYM_EXIT_Y 350

// Space bar scancode
`define START_KEY 8'h2C
`define STEP_DELAY 8

`endif

//--- hw/pixelCompositor.sv
`timescale 1ns/1ns
`default_nettype none

module pixelCompositor import gamePkg::*, videoPkg::*; (
	input logic Clk,
	input logic rstN,
	input gameMode mode,
	input logic active,
	input logic charHere,
	input logic inMap,
	input logic inMenu,
	input romData data,
	output pixelOut pixel
);

	typedef struct packed {
		gameMode mode;
		logic active;
		logic charHere;
		logic inMap;
		logic inMenu;
	} pixelFlags;

	pixelFlags flagsQ;
	pixelOut nextPixel;

	// Line the flags up with the ROM read
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			flagsQ <= '0;
		end else begin
			flagsQ <= '{mode: mode, active: active, charHere: charHere,
				inMap: inMap, inMenu: inMenu};
		end
	end

	always_comb begin
		nextPixel = '{layer: BLANK, index: 8'd0};
		case (flagsQ.mode)
			START: begin
				if (flagsQ.active && flagsQ.inMenu) begin
					nextPixel = '{layer: MENU, index: 8'(data.menuIndex)};
				end
			end
			OVERWORLD: begin
				// Index 0 of the sprite is transparent
				if (flagsQ.active && flagsQ.inMap) begin
					if (flagsQ.charHere && data.spriteIndex != '0) begin
						nextPixel = '{layer: SPRITE, index: 8'(data.spriteIndex)};
					end else begin
						nextPixel = '{layer: MAP, index: data.mapIndex};
					end
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pixel <= '{layer: BLANK, index: 8'd0};
		end else begin
			pixel <= nextPixel;
		end
	end

endmodule

`default_nettype wire

//--- hw/scanAddrGen.sv
`timescale 1ns/1ns
`default_nettype none

`include "overworld_defs.svh"

module scanAddrGen import gamePkg::*, videoPkg::*; (
	input scanIn scan,
	input camPos camera,
	input animState anim,
	output logic [spriteAddrW-1:0] spriteAddr,
	output logic [mapAddrW-1:0] mapAddr,
	output logic [mapAddrW-1:0] menuAddr,
	output logic charHere,
	output logic inMap,
	output logic inMenu
);

	logic signed [13:0] worldX;
	logic signed [13:0] worldY;
	logic [11:0] mapCol;
	logic [11:0] mapRow;
	logic [coordW-1:0] boxCol;
	logic [coordW-1:0] boxRow;
	logic [coordW-1:0] menuRow;
	logic [1:0] dirSlot;
	logic [7:0] phaseOff;

	// World pixel under the beam
	assign worldX = $signed({1'b0, scan.drawX}) + camera.x;
	assign worldY = $signed({1'b0, scan.drawY}) + camera.y;
	assign mapCol = 12'(worldX >>> `MAP_SHIFT);
	assign mapRow = 12'(worldY >>> `MAP_SHIFT);

	assign inMap = !worldX[13] && !worldY[13] && mapCol < `MAP_W && mapRow < `MAP_H;
	assign mapAddr = (worldX[13] || worldY[13]) ? '0 :
		mapAddrW'(mapRow * `MAP_W + mapCol);

	assign charHere = scan.drawX >= `SPRITE_X0 && scan.drawX < `SPRITE_X0 + `SPRITE_W &&
		scan.drawY >= `SPRITE_Y0 && scan.drawY < `SPRITE_Y0 + `SPRITE_H;
	assign boxCol = scan.drawX - coordW'(`SPRITE_X0);
	assign boxRow = scan.drawY - coordW'(`SPRITE_Y0);

	// Sheet order is down, left, up, right
	assign dirSlot = 2'(anim.dir + 2'd2);

	always_comb begin
		case (anim.phase)
			stride1: phaseOff = 8'd0;
			stride2: phaseOff = 8'(2 * `SPRITE_W);
			default: phaseOff = 8'(`SPRITE_W);
		endcase
	end

	assign spriteAddr = charHere ? spriteAddrW'(`SHEET_W * boxRow + boxCol +
		dirSlot * `DIR_STRIDE + phaseOff) : '0;

	// Menu image is scaled 3x vertically and 3.2x horizontally
	assign inMenu = scan.drawY >= `MENU_Y0 && scan.drawY <= `MENU_Y1;
	assign menuRow = (scan.drawY - coordW'(`MENU_Y0)) / 3;
	assign menuAddr = inMenu ? mapAddrW'(menuRow * `MENU_ROW + scan.drawX * 10 / 32) : '0;

endmodule

`default_nettype wire

//--- hw/videoPkg.sv
`default_nettype none

`include "overworld_defs.svh"

package videoPkg;

	// Scan counters run past the visible area during blanking
	localparam int coordW = $clog2((`SCREEN_W > `SCREEN_H) ? `SCREEN_W : `SCREEN_H) + 1;
	localparam int spriteAddrW = 13;
	localparam int mapAddrW = 19;

	typedef struct packed {
		logic [coordW-1:0] drawX;
		logic [coordW-1:0] drawY;
		logic active;
	} scanIn;

	typedef struct packed {
		logic [spriteAddrW-1:0] spriteAddr;
		logic [mapAddrW-1:0] mapAddr;
		logic [mapAddrW-1:0] menuAddr;
		logic [mapAddrW-1:0] collisionAddr;
	} romAddr;

	typedef struct packed {
		logic [3:0] spriteIndex;
		logic [7:0] mapIndex;
		logic [4:0] menuIndex;
		// [0] right, [1] down, [2] left, [3] up
		logic [3:0] collisionBits;
	} romData;

	typedef enum logic [1:0] {
		BLANK,
		MENU,
		MAP,
		SPRITE
	} pixelLayer;

	typedef struct packed {
		pixelLayer layer;
		logic [7:0] index;
	} pixelOut;

endpackage

`default_nettype wire

//--- hw/walkAnimator.sv
`timescale 1ns/1ns
`default_nettype none

`include "overworld_defs.svh"

module walkAnimator import gamePkg::*; (
	input logic Clk,
	input logic rstN,
	input logic frameTick,
	input logic moving,
	input walkDir direction,
	input gameMode mode,
	input logic spawn,
	output animState anim,
	output logic stepReq
);

	localparam int delayW = $clog2(`STEP_DELAY);
	localparam animState restDown = '{dir: down, phase: rest1};

	logic [delayW-1:0] delayCnt;
	logic tickLive;
	walkPhase nextPhase;

	assign tickLive = frameTick && mode != START && !spawn;
	assign nextPhase = walkPhase'(anim.phase + 2'd1);

	// Only a walk in the facing direction moves the camera
	assign stepReq = tickLive && moving && direction == anim.dir;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			anim <= restDown;
			delayCnt <= '0;
		end else if (spawn) begin
			anim <= restDown;
			delayCnt <= '0;
		end else if (tickLive) begin
			if (!moving) begin
				anim.phase <= rest1;
			end else if (direction != anim.dir) begin
				// Turning costs one tick without a step
				anim.dir <= direction;
				anim.phase <= rest1;
			end else begin
				if (delayCnt == '0) begin
					anim.phase <= nextPhase;
				end
				if (delayCnt == delayW'(`STEP_DELAY - 1)) begin
					delayCnt <= '0;
				end else begin
					delayCnt <= delayCnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0] lfsrState = 16'd5;
logic [7:0] spriteTab [0:255];
logic [7:0] mapTab [0:255];
logic [7:0] menuTab [0:255];
int blockAddr;
logic [3:0] blockBits;
int errCount = 0;

// Galois LFSR, one step per bit taken
function automatic logic lfsrBit();
	logic lsb;
	lsb = lfsrState[0];
	lfsrState = lfsrState >> 1;
	if (lsb) begin
		lfsrState = lfsrState ^ 16'hB400;
	end
	return lsb;
endfunction

function automatic int randBits(int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		v = (v << 1) | int'(lfsrBit());
	end
	return v;
endfunction

// Folds every address bit into a table slot
function automatic int hashAddr(int a);
	return (a ^ (a >> 8) ^ (a >> 16)) & 255;
endfunction

function automatic int spriteRom(int a);
	if (a % 5 == 0) begin
		return 0;
	end
	return spriteTab[hashAddr(a)] & 15;
endfunction

function automatic int mapRom(int a);
	return mapTab[hashAddr(a)];
endfunction

function automatic int menuRom(int a);
	return menuTab[hashAddr(a)] & 31;
endfunction

function automatic int collRom(int a);
	return (a == blockAddr) ? int'(blockBits) : 0;
endfunction

function automatic logic inBox(int x, int y);
	return x >= 311 && x <= 329 && y >= 340 && y <= 368;
endfunction

function automatic int refSprite(int x, int y, int dir, int phase);
	int base;
	int off;
	if (!inBox(x, y)) begin
		return 0;
	end
	case (dir)
		0: base = 114;
		1: base = 171;
		2: base = 0;
		default: base = 57;
	endcase
	case (phase)
		1: off = 0;
		3: off = 38;
		default: off = 19;
	endcase
	return 228 * (y - 340) + (x - 311) + base + off;
endfunction

function automatic int refMap(int x, int y, int camX, int camY);
	int wx;
	int wy;
	wx = x + camX;
	wy = y + camY;
	if (wx < 0 || wy < 0) begin
		return 0;
	end
	return ((wy / 4) * 320 + wx / 4) & 19'h7FFFF;
endfunction

function automatic int refMenu(int x, int y);
	if (y < 80 || y > 370) begin
		return 0;
	end
	return ((y - 80) / 3) * 200 + (x * 10) / 32;
endfunction

function automatic int refColl(int camX, int camY);
	return (((camY + 340) >>> 2) * 320 + ((camX + 311) >>> 2)) & 19'h7FFFF;
endfunction

function automatic pixelOut refPixel(int mode, int x, int y, logic active,
	int camX, int camY, int dir, int phase);
	pixelOut p;
	int wx;
	int wy;
	int spr;
	p = '{layer: BLANK, index: 8'd0};
	wx = x + camX;
	wy = y + camY;
	if (mode == 0 && active && y >= 80 && y <= 370) begin
		p = '{layer: MENU, index: 8'(menuRom(refMenu(x, y)))};
	end else if (mode == 1 && active && wx >= 0 && wy >= 0 && wx < 1280 && wy < 960) begin
		spr = spriteRom(refSprite(x, y, dir, phase));
		if (inBox(x, y) && spr != 0) begin
			p = '{layer: SPRITE, index: 8'(spr)};
		end else begin
			p = '{layer: MAP, index: 8'(mapRom(refMap(x, y, camX, camY)))};
		end
	end
	return p;
endfunction

task automatic checkVal(string what, int got, int exp);
	if (got !== exp) begin
		errCount++;
		$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		$display("Some tests failed");
		$fatal(1);
	end
endtask

`endif

//--- verification/tbOverworld.sv
`timescale 1ns/1ns
`default_nettype none

module tbOverworld import gamePkg::*, videoPkg::*;;

	`include "overworld_defs.svh"
	`include "tbModel.svh"

	// About 370 ticks of 6 or 7 cycles plus about 260 reset and scan cycles, with margin
	localparam int timeoutCycles = 3000;

	logic Clk;
	logic rstN;
	logic frameTick;
	logic [7:0] keycode;
	logic moving;
	walkDir direction;
	scanIn scan;
	romAddr rom;
	romAddr addrQ;
	romData data;
	pixelOut pixel;

	logic checking = 1'b0;
	int cycles = 0;
	pixelOut expNext;
	pixelOut expPix;

	// Reference state
	int mMode;
	int mCamX;
	int mCamY;
	int mDir;
	int mPhase;
	int mDelay;

	overworldRenderer u_dut (
		.Clk(Clk),
		.rstN(rstN),
		.frameTick(frameTick),
		.keycode(keycode),
		.moving(moving),
		.direction(direction),
		.scan(scan),
		.rom(rom),
		.data(data),
		.pixel(pixel)
	);

	initial begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// ROM models, one cycle of latency
	always @(posedge Clk) begin
		addrQ <= rom;
	end

	always @(negedge Clk) begin
		data.spriteIndex = 4'(spriteRom(int'(addrQ.spriteAddr)));
		data.mapIndex = 8'(mapRom(int'(addrQ.mapAddr)));
		data.menuIndex = 5'(menuRom(int'(addrQ.menuAddr)));
		data.collisionBits = 4'(collRom(int'(addrQ.collisionAddr)));
	end

	// Expected pixel pipeline and address compare
	always @(posedge Clk) begin
		expNext <= refPixel(mMode, int'(scan.drawX), int'(scan.drawY), scan.active,
			mCamX, mCamY, mDir, mPhase);
		expPix <= expNext;
		if (checking) begin
			checkVal("spriteAddr", int'(rom.spriteAddr),
				refSprite(int'(scan.drawX), int'(scan.drawY), mDir, mPhase));
			checkVal("mapAddr", int'(rom.mapAddr),
				refMap(int'(scan.drawX), int'(scan.drawY), mCamX, mCamY));
			checkVal("menuAddr", int'(rom.menuAddr),
				refMenu(int'(scan.drawX), int'(scan.drawY)));
			checkVal("collisionAddr", int'(rom.collisionAddr), refColl(mCamX, mCamY));
		end
	end

	always @(negedge Clk) begin
		if (checking) begin
			checkVal("pixel layer", int'(pixel.layer), int'(expPix.layer));
			checkVal("pixel index", int'(pixel.index), int'(expPix.index));
		end
	end

	always @(posedge Clk) begin
		cycles++;
		if (cycles > timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic scanPix(int x, int y, logic act);
		@(negedge Clk);
		scan = '{drawX: coordW'(x), drawY: coordW'(y), active: act};
		repeat (3) @(negedge Clk);
	endtask

	// One frame tick, with the reference updated after the DUT edge
	task automatic tickFrame();
		int newMode;
		int camX;
		int camY;
		int dir;
		int phase;
		int delay;
		int bits;
		logic ok;
		logic doSpawn;
		int sx;
		int sy;
		@(negedge Clk);
		frameTick = 1'b1;
		newMode = mMode;
		camX = mCamX;
		camY = mCamY;
		dir = mDir;
		phase = mPhase;
		delay = mDelay;
		doSpawn = 1'b0;
		sx = 100;
		sy = 100;
		if (mMode == 0 && keycode == `START_KEY) begin
			newMode = 1;
			doSpawn = 1'b1;
		end else if (mMode == 1 && mCamX + 311 > 411 && mCamX + 311 < 440 &&
			mCamY + 340 == 420) begin
			newMode = 2;
			doSpawn = 1'b1;
			sx = 0;
			sy = 0;
		end else if (mMode == 2 && mCamY + 340 == 350) begin
			newMode = 1;
			doSpawn = 1'b1;
		end
		if (mMode != 0) begin
			if (!moving) begin
				phase = 0;
			end else if (int'(direction) != mDir) begin
				dir = int'(direction);
				phase = 0;
			end else begin
				if (mDelay == 0) begin
					phase = (mPhase + 1) % 4;
				end
				delay = (mDelay + 1) % 8;
				bits = collRom(refColl(mCamX, mCamY));
				case (mDir)
					0: ok = mCamY > -340 && !bits[3];
					1: ok = mCamX < 951 && !bits[0];
					2: ok = mCamY < 594 && !bits[1];
					default: ok = mCamX > -311 && !bits[2];
				endcase
				if (ok) begin
					case (mDir)
						0: camY = mCamY - 1;
						1: camX = mCamX + 1;
						2: camY = mCamY + 1;
						default: camX = mCamX - 1;
					endcase
				end
			end
		end
		@(negedge Clk);
		frameTick = 1'b0;
		mMode = newMode;
		mCamX = camX;
		mCamY = camY;
		mDir = dir;
		mPhase = phase;
		mDelay = delay;
		if (doSpawn) begin
			@(negedge Clk);
			mCamX = sx;
			mCamY = sy;
			mDir = 2;
			mPhase = 0;
			mDelay = 0;
		end
		repeat (4) @(negedge Clk);
	endtask

	initial begin
		int n;
		rstN = 1'b0;
		frameTick = 1'b0;
		keycode = 8'd0;
		moving = 1'b0;
		direction = down;
		scan = '0;
		data = '0;
		blockAddr = -1;
		blockBits = 4'd0;
		mMode = 0;
		mCamX = 0;
		mCamY = 0;
		mDir = 2;
		mPhase = 0;
		mDelay = 0;
		for (int i = 0; i < 256; i++) begin
			spriteTab[i] = 8'(randBits(8));
			mapTab[i] = 8'(randBits(8));
			menuTab[i] = 8'(randBits(8));
		end
		repeat (16) @(negedge Clk);
		rstN = 1'b1;
		checking = 1'b1;

		// Start menu
		scanPix(10, 10, 1'b1);
		for (int i = 0; i < 6; i++) begin
			scanPix(37 * i + 50, 80 + 58 * i, 1'b1);
		end
		scanPix(600, 370, 1'b1);
		scanPix(200, 200, 1'b0);

		keycode = `START_KEY;
		tickFrame();
		keycode = 8'd0;
		checkVal("collisionAddr at spawn", int'(rom.collisionAddr),
			refColl(`SPAWN_X, `SPAWN_Y));

		// Walk right, then turn up
		scanPix(315, 345, 1'b1);
		moving = 1'b1;
		direction = right;
		repeat (17) tickFrame();
		checkVal("collisionAddr after walk", int'(rom.collisionAddr),
			refColl(`SPAWN_X + 16, `SPAWN_Y));
		direction = up;
		tickFrame();

		// Blocked by the collision map
		blockAddr = refColl(mCamX, mCamY);
		blockBits = 4'b1000;
		repeat (2) tickFrame();
		checkVal("collisionAddr while blocked", int'(rom.collisionAddr),
			refColl(`SPAWN_X + 16, `SPAWN_Y));
		blockAddr = -1;
		moving = 1'b0;
		tickFrame();

		// Sprite box and map edges
		for (int y = 344; y <= 345; y++) begin
			for (int x = 309; x <= 331; x++) begin
				scanPix(x, y, 1'b1);
			end
		end
		scanPix(1500, 100, 1'b1);
		scanPix(320, 350, 1'b0);

		// Door, gym and exit
		moving = 1'b1;
		n = 0;
		while (mMode != 2 && n < 40) begin
			tickFrame();
			n++;
		end
		checkVal("collisionAddr in gym", int'(rom.collisionAddr), refColl(0, 0));
		scanPix(100, 100, 1'b1);
		scanPix(320, 350, 1'b1);

		// Left camera bound, reached from the gym spawn
		direction = left;
		repeat (314) tickFrame();
		checkVal("collisionAddr at bound", int'(rom.collisionAddr),
			refColl(`CAM_MIN_X, 0));
		direction = down;
		n = 0;
		while (mMode != 1 && n < 20) begin
			tickFrame();
			n++;
		end
		checkVal("collisionAddr after exit", int'(rom.collisionAddr),
			refColl(`SPAWN_X, `SPAWN_Y));
		moving = 1'b0;
		scanPix(320, 350, 1'b1);
		repeat (4) @(negedge Clk);

		if (errCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
